/* flist.f */
hw/fpu_seq_pkg.sv
hw/fp_decoder.sv
hw/fp_regfile.sv
hw/fp_scoreboard.sv
hw/fp_dispatcher.sv
hw/fp_retire.sv
hw/fpu_sequencer.sv
sim/tb_fpu_sequencer.sv

/* Bender.yml */
package:
  name: fpu_sequencer

sources:
  - hw/fpu_seq_pkg.sv
  - hw/fp_decoder.sv
  - hw/fp_regfile.sv
  - hw/fp_scoreboard.sv
  - hw/fp_dispatcher.sv
  - hw/fp_retire.sv
  - hw/fpu_sequencer.sv
  - target: simulation
    files:
      - sim/tb_fpu_sequencer.sv

/* sim/tb_fpu_sequencer.sv */
////////////////////
// FPU sequencer testbench
// Random instruction mix against an accelerator model and a shadow FPR
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_fpu_sequencer;

  import fpu_seq_pkg::*;

  // Sum of 32 + 40 + 80 + 90 + 20 + 60 issued instructions
  localparam int unsigned NrIssued = 322;
  localparam int unsigned Limit    = NrIssued * 30;
  // Keeps register fields in x0..x7 so hazards show up often
  localparam logic [31:0] RegHigh  = 32'hC18C_0C00;

  logic clk_i = 1'b0;
  logic reset_i;
  logic issue_valid_i, issue_ready_o, resp_accept_o, resp_writeback_o, resp_exc_o;
  instr_u issue_instr_i, acc_instr_o;
  issue_id_t issue_id_i, acc_id_o, acc_result_id_i, result_id_o;
  fp_data_t issue_rs1_i, issue_rs2_i, acc_rs1_o, acc_rs2_o, acc_rs3_o;
  fp_data_t acc_result_data_i, result_data_o;
  logic acc_valid_o, acc_ready_i, acc_resp_accept_i, acc_resp_writeback_i;
  logic acc_result_valid_i, acc_result_ready_o, result_valid_o, result_ready_i;

  // Stimulus state
  logic [31:0] rng = 32'd99;
  int unsigned cycles = 0, errors = 0, checks = 0, issued = 0, test_err = 0, test_cnt = 0;
  logic cur_valid = 1'b0, fired, c_fs1, c_fs2, c_fs3, c_fd;
  int c_cls;
  logic [31:0] cur_word;
  issue_id_t cur_id;
  fp_data_t cur_rs1, cur_rs2;
  logic nxt_acc_rdy = 1'b0, nxt_res_rdy = 1'b0, nxt_acc_acc = 1'b0, nxt_acc_wb = 1'b0;

  // Reference model
  fp_data_t fpr_m [32];
  logic [31:0] sb_m = '0;
  logic mv_full_m = 1'b0;
  issue_id_t mv_id_m;
  fp_data_t mv_data_m;
  issue_id_t q_id [$];
  int q_delay [$];
  logic ret_valid = 1'b0;
  issue_id_t ret_id;
  fp_data_t ret_data;

  fpu_sequencer fpu_sequencer_inst (.*);

  always #20 clk_i = ~clk_i;

  // Run limit
  initial begin
    while (cycles < Limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: run exceeded %0d cycles", Limit);
    $display("Simulation finished: FAIL");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_data(input string name, input fp_data_t got, input fp_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_id(input string name, input issue_id_t got, input issue_id_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_instr(input string name, input instr_u got, input instr_u exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  ////////////////////
  // One clock cycle
  ////////////////////

  task automatic step();
    logic busy, local_op, acc_core, pop, twr, ret_done;
    issue_id_t exp_id;
    fpr_addr_t fs1, fs2, fs3, fd;
    @(negedge clk_i);
    issue_valid_i        = cur_valid;
    issue_instr_i        = cur_word;
    issue_id_i           = cur_id;
    issue_rs1_i          = cur_rs1;
    issue_rs2_i          = cur_rs2;
    acc_ready_i          = nxt_acc_rdy;
    acc_resp_accept_i    = nxt_acc_acc;
    acc_resp_writeback_i = nxt_acc_wb;
    result_ready_i       = nxt_res_rdy;
    acc_result_valid_i   = ret_valid;
    acc_result_id_i      = ret_id;
    acc_result_data_i    = ret_data;
    #10;
    // Result side against the state before this edge
    acc_core = ret_valid && !ret_id[FprTagBit];
    twr      = ret_valid && ret_id[FprTagBit];
    ret_done = ret_valid && (ret_id[FprTagBit] || result_ready_i);
    pop      = 1'b0;
    if (ret_valid) begin
      check_flag("acc_result_ready_o", acc_result_ready_o, ret_id[FprTagBit] || result_ready_i);
    end
    check_flag("result_valid_o", result_valid_o, acc_core || mv_full_m);
    if (acc_core) begin
      check_id("result_id_o", result_id_o, ret_id);
      check_data("result_data_o", result_data_o, ret_data);
    end else if (mv_full_m) begin
      check_id("result_id_o", result_id_o, mv_id_m);
      check_data("result_data_o", result_data_o, mv_data_m);
      pop = result_ready_i;
    end
    // Issue side
    fs1      = cur_word[19:15];
    fs2      = cur_word[24:20];
    fs3      = cur_word[31:27];
    fd       = cur_word[11:7];
    busy     = (c_fs1 && sb_m[fs1]) || (c_fs2 && sb_m[fs2]) || (c_fs3 && sb_m[fs3]) ||
               (c_fd && sb_m[fd]);
    local_op = c_cls >= 2;
    check_flag("issue_ready_o", issue_ready_o, cur_valid && !busy &&
               !(c_cls == 2 && mv_full_m) && (local_op || acc_ready_i));
    check_flag("acc_valid_o", acc_valid_o, cur_valid && !local_op && !busy);
    if (cur_valid && issue_ready_o) begin
      if (local_op) begin
        check_flag("resp_accept_o", resp_accept_o, c_cls == 2);
        check_flag("resp_writeback_o", resp_writeback_o, c_cls == 2);
        check_flag("resp_exc_o", resp_exc_o, c_cls == 4);
      end else begin
        exp_id = (c_cls == 1 && c_fd) ? {1'b1, fd} : cur_id;
        check_flag("resp_accept_o", resp_accept_o, acc_resp_accept_i);
        check_flag("resp_writeback_o", resp_writeback_o, acc_resp_writeback_i);
        check_flag("resp_exc_o", resp_exc_o, 1'b0);
        check_instr("acc_instr_o", acc_instr_o, cur_word);
        check_data("acc_rs1_o", acc_rs1_o, c_fs1 ? fpr_m[fs1] : cur_rs1);
        check_data("acc_rs2_o", acc_rs2_o, c_fs2 ? fpr_m[fs2] : cur_rs2);
        check_data("acc_rs3_o", acc_rs3_o, c_fs3 ? fpr_m[fs3] : '0);
        check_id("acc_id_o", acc_id_o, exp_id);
        q_id.push_back(exp_id);
        q_delay.push_back(next_rand() % 8);
      end
      if (c_cls == 3) begin
        fpr_m[fd] = cur_rs1;
      end else if (c_cls == 2) begin
        mv_full_m = 1'b1;
        mv_id_m   = cur_id;
        mv_data_m = fpr_m[fs1];
      end else if (c_cls == 1 && c_fd) begin
        sb_m[fd] = 1'b1;
      end
      fired     = 1'b1;
      cur_valid = 1'b0;
    end
    if (twr) begin
      fpr_m[ret_id[4:0]] = ret_data;
      sb_m[ret_id[4:0]]  = 1'b0;
    end
    if (ret_done) ret_valid = 1'b0;
    if (pop) mv_full_m = 1'b0;
    // Accelerator returns in order after a random delay
    if (!ret_valid && q_id.size() > 0) begin
      if (q_delay[0] == 0) begin
        ret_valid = 1'b1;
        ret_id    = q_id.pop_front();
        ret_data  = next_rand();
        void'(q_delay.pop_front());
      end else begin
        q_delay[0]--;
      end
    end
    nxt_acc_rdy = (next_rand() % 4) != 0;
    nxt_res_rdy = (next_rand() % 4) != 0;
    nxt_acc_acc = next_rand() % 2;
    nxt_acc_wb  = next_rand() % 2;
  endtask

  ////////////////////
  // Instruction drivers
  ////////////////////

  task automatic issue_instr(input logic [31:0] word, input int cls, input logic u1,
                             input logic u2, input logic u3, input logic ud,
                             input fp_data_t rs1);
    logic [31:0] r;
    r         = next_rand();
    cur_word  = word;
    cur_id    = {1'b0, r[4:0]};
    cur_rs1   = rs1;
    cur_rs2   = next_rand();
    c_cls     = cls;
    c_fs1     = u1;
    c_fs2     = u2;
    c_fs3     = u3;
    c_fd      = ud;
    cur_valid = 1'b1;
    fired     = 1'b0;
    while (!fired) step();
    issued++;
  endtask

  task automatic mv_wx(input int rd, input fp_data_t val);
    logic [31:0] r;
    r = next_rand();
    issue_instr(FmvWXMatch | (32'(rd) << 7) | (r & 32'h000F_8000), 3, 0, 0, 0, 1, val);
  endtask

  task automatic mv_xw(input int fs);
    logic [31:0] r;
    r = next_rand();
    issue_instr(FmvXWMatch | (32'(fs) << 15) | (r & 32'h0000_0F80), 2, 1, 0, 0, 0,
                next_rand());
  endtask

  task automatic fwd_op();
    logic [31:0] r;
    r = next_rand();
    issue_instr({r[31:7], 7'h33}, 0, 0, 0, 0, 0, next_rand());
  endtask

  // Kinds 0..16 are arithmetic or vector-scalar and 17..20 unsupported
  task automatic fp_op(input int k);
    logic [31:0] m, mk, r;
    case (k)
      0: {m, mk} = {FaddSMatch, FaddSMask};
      1: {m, mk} = {FsubSMatch, FsubSMask};
      2: {m, mk} = {FmulSMatch, FmulSMask};
      3: {m, mk} = {FsgnjSMatch, FsgnjSMask};
      4: {m, mk} = {FminSMatch, FminSMask};
      5: {m, mk} = {FmaxSMatch, FmaxSMask};
      6: {m, mk} = {FeqSMatch, FeqSMask};
      7: {m, mk} = {FltSMatch, FltSMask};
      8: {m, mk} = {FleSMatch, FleSMask};
      9: {m, mk} = {FclassSMatch, FclassSMask};
      10: {m, mk} = {FcvtSWMatch, FcvtSWMask};
      11: {m, mk} = {FcvtWSMatch, FcvtWSMask};
      12: {m, mk} = {FmaddSMatch, FmaddSMask};
      13: {m, mk} = {FnmaddSMatch, FnmaddSMask};
      14: {m, mk} = {VfaddVfMatch, VfaddVfMask};
      15: {m, mk} = {VfmulVfMatch, VfmulVfMask};
      16: {m, mk} = {VfmaccVfMatch, VfmaccVfMask};
      17: {m, mk} = {FdivSMatch, FdivSMask};
      18: {m, mk} = {FsqrtSMatch, FsqrtSMask};
      19: {m, mk} = {FlwMatch, FlwMask};
      default: {m, mk} = {FswMatch, FswMask};
    endcase
    r = next_rand();
    issue_instr(m | (r & ~mk & ~RegHigh), (k >= 17) ? 4 : 1,
                k != 10 && k < 17, k <= 8 || k == 12 || k == 13, k == 12 || k == 13,
                k < 6 || k == 10 || k == 12 || k == 13, next_rand());
  endtask

  task automatic start_test();
    test_err = errors;
    test_cnt = issued;
  endtask

  // Lets every outstanding result retire before the next test
  task automatic end_test(input string name);
    while (ret_valid || q_id.size() > 0 || mv_full_m) step();
    $display("Test %s: %0d instructions, %0d errors", name, issued - test_cnt,
             errors - test_err);
  endtask

  initial begin
    logic [31:0] v;
    reset_i              = 1'b1;
    issue_valid_i        = 1'b0;
    issue_instr_i        = '0;
    issue_id_i           = '0;
    issue_rs1_i          = '0;
    issue_rs2_i          = '0;
    acc_ready_i          = 1'b0;
    acc_resp_accept_i    = 1'b0;
    acc_resp_writeback_i = 1'b0;
    acc_result_valid_i   = 1'b0;
    acc_result_id_i      = '0;
    acc_result_data_i    = '0;
    result_ready_i       = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    start_test();
    for (int i = 0; i < 32; i++) mv_wx(i, next_rand());
    end_test("fpr_init");

    start_test();
    for (int i = 0; i < 40; i++) fwd_op();
    end_test("forward");

    start_test();
    for (int i = 0; i < 40; i++) begin
      v = next_rand() % 32;
      mv_wx(v, next_rand());
      mv_xw(v);
    end
    end_test("move_roundtrip");

    start_test();
    for (int i = 0; i < 90; i++) begin
      if (next_rand() % 3 == 0) mv_xw(next_rand() % 8);
      else fp_op(next_rand() % 17);
    end
    end_test("arith_hazard");

    start_test();
    for (int i = 0; i < 20; i++) fp_op(17 + next_rand() % 4);
    end_test("illegal");

    start_test();
    for (int i = 0; i < 60; i++) begin
      if (next_rand() % 2 == 0) fwd_op();
      else mv_xw(next_rand() % 32);
    end
    end_test("result_mix");

    $display("Instructions: %0d, checks: %0d, errors: %0d", issued, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hw/fpu_sequencer.sv */
////////////////////
// Scalar FP sequencer top
// Sits between the core and the vector accelerator
////////////////////

`timescale 1ns/1ps
`default_nettype none

module fpu_sequencer (
  input  logic                   clk_i,
  input  logic                   reset_i,
  // Core issue channel
  input  logic                   issue_valid_i,
  input  fpu_seq_pkg::instr_u    issue_instr_i,
  input  fpu_seq_pkg::issue_id_t issue_id_i,
  input  fpu_seq_pkg::fp_data_t  issue_rs1_i,
  input  fpu_seq_pkg::fp_data_t  issue_rs2_i,
  output logic                   issue_ready_o,
  output logic                   resp_accept_o,
  output logic                   resp_writeback_o,
  output logic                   resp_exc_o,
  // Accelerator issue channel
  output logic                   acc_valid_o,
  output fpu_seq_pkg::instr_u    acc_instr_o,
  output fpu_seq_pkg::issue_id_t acc_id_o,
  output fpu_seq_pkg::fp_data_t  acc_rs1_o,
  output fpu_seq_pkg::fp_data_t  acc_rs2_o,
  output fpu_seq_pkg::fp_data_t  acc_rs3_o,
  input  logic                   acc_ready_i,
  input  logic                   acc_resp_accept_i,
  input  logic                   acc_resp_writeback_i,
  // Result channels
  input  logic                   acc_result_valid_i,
  input  fpu_seq_pkg::issue_id_t acc_result_id_i,
  input  fpu_seq_pkg::fp_data_t  acc_result_data_i,
  output logic                   acc_result_ready_o,
  output logic                   result_valid_o,
  output fpu_seq_pkg::issue_id_t result_id_o,
  output fpu_seq_pkg::fp_data_t  result_data_o,
  input  logic                   result_ready_i
);

  import fpu_seq_pkg::*;

  fpr_addr_t     fd;
  fpr_addr_t     fs1;
  fpr_addr_t     fs2;
  fpr_addr_t     fs3;
  logic          use_fs1;
  logic          use_fs2;
  logic          use_fs3;
  logic          use_fd;
  fp_class_e     fp_class;
  logic          illegal;
  logic          operands_busy;
  logic          issue_fire;
  logic          sb_set;
  logic          move_full;
  fp_data_t [2:0] fpr_rdata;
  logic          acc_wr_en;
  fpr_addr_t     acc_wr_addr;
  fp_data_t      acc_wr_data;
  logic          mv_wr_en;
  fpr_addr_t     mv_wr_addr;
  fp_data_t      mv_wr_data;

  // rs3 only exists in the R4 view
  assign fd  = issue_instr_i.r.rd;
  assign fs1 = issue_instr_i.r.rs1;
  assign fs2 = issue_instr_i.r.rs2;
  assign fs3 = issue_instr_i.r4.rs3;

  assign acc_instr_o = issue_instr_i;
  assign sb_set      = issue_fire && use_fd && fp_class == Arith;

  fp_decoder fp_decoder_inst (
    .issue_valid_i(issue_valid_i),
    .issue_instr_i(issue_instr_i),
    .use_fs1_o    (use_fs1),
    .use_fs2_o    (use_fs2),
    .use_fs3_o    (use_fs3),
    .use_fd_o     (use_fd),
    .fp_class_o   (fp_class),
    .illegal_o    (illegal)
  );

  fp_regfile fp_regfile_inst (
    .clk_i  (clk_i),
    .raddr_i({fs3, fs2, fs1}),
    .rdata_o(fpr_rdata),
    .we_i   ({mv_wr_en, acc_wr_en}),
    .waddr_i({mv_wr_addr, acc_wr_addr}),
    .wdata_i({mv_wr_data, acc_wr_data})
  );

  fp_scoreboard fp_scoreboard_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .use_fs1_i (use_fs1),
    .use_fs2_i (use_fs2),
    .use_fs3_i (use_fs3),
    .use_fd_i  (use_fd),
    .fs1_i     (fs1),
    .fs2_i     (fs2),
    .fs3_i     (fs3),
    .fd_i      (fd),
    .set_i     (sb_set),
    .set_addr_i(fd),
    .clr_i     (acc_wr_en),
    .clr_addr_i(acc_wr_addr),
    .busy_o    (operands_busy)
  );

  fp_dispatcher fp_dispatcher_inst (
    .issue_valid_i       (issue_valid_i),
    .acc_ready_i         (acc_ready_i),
    .busy_i              (operands_busy),
    .move_full_i         (move_full),
    .use_fs1_i           (use_fs1),
    .use_fs2_i           (use_fs2),
    .use_fs3_i           (use_fs3),
    .use_fd_i            (use_fd),
    .fp_class_i          (fp_class),
    .illegal_i           (illegal),
    .fs1_data_i          (fpr_rdata[0]),
    .fs2_data_i          (fpr_rdata[1]),
    .fs3_data_i          (fpr_rdata[2]),
    .issue_rs1_i         (issue_rs1_i),
    .issue_rs2_i         (issue_rs2_i),
    .issue_id_i          (issue_id_i),
    .fd_i                (fd),
    .acc_resp_accept_i   (acc_resp_accept_i),
    .acc_resp_writeback_i(acc_resp_writeback_i),
    .issue_ready_o       (issue_ready_o),
    .issue_fire_o        (issue_fire),
    .acc_valid_o         (acc_valid_o),
    .acc_rs1_o           (acc_rs1_o),
    .acc_rs2_o           (acc_rs2_o),
    .acc_rs3_o           (acc_rs3_o),
    .acc_id_o            (acc_id_o),
    .resp_accept_o       (resp_accept_o),
    .resp_writeback_o    (resp_writeback_o),
    .resp_exc_o          (resp_exc_o)
  );

  fp_retire fp_retire_inst (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .acc_result_valid_i(acc_result_valid_i),
    .acc_result_id_i   (acc_result_id_i),
    .acc_result_data_i (acc_result_data_i),
    .acc_result_ready_o(acc_result_ready_o),
    .result_valid_o    (result_valid_o),
    .result_id_o       (result_id_o),
    .result_data_o     (result_data_o),
    .result_ready_i    (result_ready_i),
    .issue_fire_i      (issue_fire),
    .fp_class_i        (fp_class),
    .issue_id_i        (issue_id_i),
    .fd_i              (fd),
    .fs1_data_i        (fpr_rdata[0]),
    .issue_rs1_i       (issue_rs1_i),
    .acc_wr_en_o       (acc_wr_en),
    .acc_wr_addr_o     (acc_wr_addr),
    .acc_wr_data_o     (acc_wr_data),
    .mv_wr_en_o        (mv_wr_en),
    .mv_wr_addr_o      (mv_wr_addr),
    .mv_wr_data_o      (mv_wr_data),
    .move_full_o       (move_full)
  );

endmodule

`default_nettype wire

/* hw/fp_retire.sv */
////////////////////
// Result retire
// Routes accelerator results and buffers one move result
////////////////////

`timescale 1ns/1ps
`default_nettype none

module fp_retire (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   acc_result_valid_i,
  input  fpu_seq_pkg::issue_id_t acc_result_id_i,
  input  fpu_seq_pkg::fp_data_t  acc_result_data_i,
  output logic                   acc_result_ready_o,
  output logic                   result_valid_o,
  output fpu_seq_pkg::issue_id_t result_id_o,
  output fpu_seq_pkg::fp_data_t  result_data_o,
  input  logic                   result_ready_i,
  input  logic                   issue_fire_i,
  input  fpu_seq_pkg::fp_class_e fp_class_i,
  input  fpu_seq_pkg::issue_id_t issue_id_i,
  input  fpu_seq_pkg::fpr_addr_t fd_i,
  input  fpu_seq_pkg::fp_data_t  fs1_data_i,
  input  fpu_seq_pkg::fp_data_t  issue_rs1_i,
  output logic                   acc_wr_en_o,
  output fpu_seq_pkg::fpr_addr_t acc_wr_addr_o,
  output fpu_seq_pkg::fp_data_t  acc_wr_data_o,
  output logic                   mv_wr_en_o,
  output fpu_seq_pkg::fpr_addr_t mv_wr_addr_o,
  output fpu_seq_pkg::fp_data_t  mv_wr_data_o,
  output logic                   move_full_o
);

  import fpu_seq_pkg::*;

  logic      acc_to_core;
  logic      mv_load;
  logic      mv_pop;
  logic      mv_valid_q;
  issue_id_t mv_id_q;
  fp_data_t  mv_data_q;

  assign acc_to_core = acc_result_valid_i && !acc_result_id_i[FprTagBit];

  ////////////////////
  // FPR writes
  ////////////////////

  // Tagged results never wait
  assign acc_result_ready_o = acc_result_id_i[FprTagBit] || result_ready_i;
  assign acc_wr_en_o        = acc_result_valid_i && acc_result_id_i[FprTagBit];
  assign acc_wr_addr_o      = acc_result_id_i[FprTagBit-1:0];
  assign acc_wr_data_o      = acc_result_data_i;

  assign mv_wr_en_o   = issue_fire_i && fp_class_i == MoveToFp;
  assign mv_wr_addr_o = fd_i;
  assign mv_wr_data_o = issue_rs1_i;

  ////////////////////
  // Move buffer
  ////////////////////

  assign mv_load = issue_fire_i && fp_class_i == MoveToInt;
  // Drains only when the accelerator leaves the channel free
  assign mv_pop  = mv_valid_q && !acc_to_core && result_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mv_valid_q <= 1'b0;
    end else if (mv_load) begin
      mv_valid_q <= 1'b1;
    end else if (mv_pop) begin
      mv_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mv_load) begin
      mv_id_q   <= issue_id_i;
      mv_data_q <= fs1_data_i;
    end
  end

  assign move_full_o = mv_valid_q;

  // Accelerator results go first
  assign result_valid_o = acc_to_core || mv_valid_q;
  assign result_id_o    = acc_to_core ? acc_result_id_i : mv_id_q;
  assign result_data_o  = acc_to_core ? acc_result_data_i : mv_data_q;

  result_hold_a : assert property (@(posedge clk_i) disable iff (reset_i)
    result_valid_o && !result_ready_i |=> result_valid_o);

endmodule

`default_nettype wire

/* hw/fp_dispatcher.sv */
////////////////////
// Issue dispatcher
// Handshake, operand substitution, tagging and response
////////////////////

`timescale 1ns/1ps
`default_nettype none

module fp_dispatcher (
  input  logic                   issue_valid_i,
  input  logic                   acc_ready_i,
  input  logic                   busy_i,
  input  logic                   move_full_i,
  input  logic                   use_fs1_i,
  input  logic                   use_fs2_i,
  input  logic                   use_fs3_i,
  input  logic                   use_fd_i,
  input  fpu_seq_pkg::fp_class_e fp_class_i,
  input  logic                   illegal_i,
  input  fpu_seq_pkg::fp_data_t  fs1_data_i,
  input  fpu_seq_pkg::fp_data_t  fs2_data_i,
  input  fpu_seq_pkg::fp_data_t  fs3_data_i,
  input  fpu_seq_pkg::fp_data_t  issue_rs1_i,
  input  fpu_seq_pkg::fp_data_t  issue_rs2_i,
  input  fpu_seq_pkg::issue_id_t issue_id_i,
  input  fpu_seq_pkg::fpr_addr_t fd_i,
  input  logic                   acc_resp_accept_i,
  input  logic                   acc_resp_writeback_i,
  output logic                   issue_ready_o,
  output logic                   issue_fire_o,
  output logic                   acc_valid_o,
  output fpu_seq_pkg::fp_data_t  acc_rs1_o,
  output fpu_seq_pkg::fp_data_t  acc_rs2_o,
  output fpu_seq_pkg::fp_data_t  acc_rs3_o,
  output fpu_seq_pkg::issue_id_t acc_id_o,
  output logic                   resp_accept_o,
  output logic                   resp_writeback_o,
  output logic                   resp_exc_o
);

  import fpu_seq_pkg::*;

  logic is_local;
  logic writes_fpr;
  logic stall;

  // Moves and illegal ops never reach the accelerator
  assign is_local   = illegal_i || fp_class_i == MoveToInt || fp_class_i == MoveToFp;
  assign writes_fpr = fp_class_i == Arith && use_fd_i;
  assign stall      = busy_i || (fp_class_i == MoveToInt && move_full_i);

  assign acc_valid_o   = issue_valid_i && !is_local && !busy_i;
  assign issue_ready_o = issue_valid_i && !stall && (is_local || acc_ready_i);
  assign issue_fire_o  = issue_valid_i && issue_ready_o;

  // FPR values replace the integer operands
  assign acc_rs1_o = use_fs1_i ? fs1_data_i : issue_rs1_i;
  assign acc_rs2_o = use_fs2_i ? fs2_data_i : issue_rs2_i;
  assign acc_rs3_o = use_fs3_i ? fs3_data_i : '0;
  assign acc_id_o  = writes_fpr ? {1'b1, fd_i} : issue_id_i;

  always_comb begin
    if (is_local) begin
      resp_accept_o    = fp_class_i == MoveToInt;
      resp_writeback_o = fp_class_i == MoveToInt;
      resp_exc_o       = illegal_i;
    end else begin
      resp_accept_o    = acc_resp_accept_i;
      resp_writeback_o = acc_resp_writeback_i;
      resp_exc_o       = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* hw/fp_scoreboard.sv */
////////////////////
// FPR scoreboard
// One pending bit per register, operand hazard check
////////////////////

`timescale 1ns/1ps
`default_nettype none

module fp_scoreboard (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   use_fs1_i,
  input  logic                   use_fs2_i,
  input  logic                   use_fs3_i,
  input  logic                   use_fd_i,
  input  fpu_seq_pkg::fpr_addr_t fs1_i,
  input  fpu_seq_pkg::fpr_addr_t fs2_i,
  input  fpu_seq_pkg::fpr_addr_t fs3_i,
  input  fpu_seq_pkg::fpr_addr_t fd_i,
  input  logic                   set_i,
  input  fpu_seq_pkg::fpr_addr_t set_addr_i,
  input  logic                   clr_i,
  input  fpu_seq_pkg::fpr_addr_t clr_addr_i,
  output logic                   busy_o
);

  import fpu_seq_pkg::*;

  logic [NrFpr-1:0] pending_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= '0;
    end else begin
      if (clr_i) begin
        pending_q[clr_addr_i] <= 1'b0;
      end
      if (set_i) begin
        pending_q[set_addr_i] <= 1'b1;
      end
    end
  end

  // RAW on sources, WAW on the destination
  assign busy_o = (use_fs1_i && pending_q[fs1_i]) || (use_fs2_i && pending_q[fs2_i]) ||
                  (use_fs3_i && pending_q[fs3_i]) || (use_fd_i && pending_q[fd_i]);

  // Tagged results only come back for issued writes
  clr_after_set_a : assert property (@(posedge clk_i) disable iff (reset_i)
    clr_i |-> pending_q[clr_addr_i]);

endmodule

`default_nettype wire

/* hw/fp_regfile.sv */
////////////////////
// Scalar FP register file
// 32 entries, three read ports, two write ports
////////////////////

`timescale 1ns/1ps
`default_nettype none

module fp_regfile (
  input  logic                         clk_i,
  input  fpu_seq_pkg::fpr_addr_t [2:0] raddr_i,
  output fpu_seq_pkg::fp_data_t  [2:0] rdata_o,
  input  logic                   [1:0] we_i,
  input  fpu_seq_pkg::fpr_addr_t [1:0] waddr_i,
  input  fpu_seq_pkg::fp_data_t  [1:0] wdata_i
);

  import fpu_seq_pkg::*;

  fp_data_t mem_q [NrFpr];

  always_ff @(posedge clk_i) begin
    for (int p = 0; p < 2; p++) begin
      if (we_i[p]) begin
        mem_q[waddr_i[p]] <= wdata_i[p];
      end
    end
  end

  // Reads see the array as of the last edge
  always_comb begin
    for (int r = 0; r < 3; r++) begin
      rdata_o[r] = mem_q[raddr_i[r]];
    end
  end

  // Scoreboard keeps result and move writes apart
  no_write_clash_a : assert property (@(posedge clk_i)
    !(we_i[0] && we_i[1] && waddr_i[0] == waddr_i[1]));

endmodule

`default_nettype wire

/* hw/fp_decoder.sv */
////////////////////
// FP instruction decoder
// Register-use flags, instruction class and legality
////////////////////

`timescale 1ns/1ps
`default_nettype none

module fp_decoder (
  input  logic                   issue_valid_i,
  input  fpu_seq_pkg::instr_u    issue_instr_i,
  output logic                   use_fs1_o,
  output logic                   use_fs2_o,
  output logic                   use_fs3_o,
  output logic                   use_fd_o,
  output fpu_seq_pkg::fp_class_e fp_class_o,
  output logic                   illegal_o
);

  import fpu_seq_pkg::*;

  function automatic logic hit(input logic [31:0] word, input logic [31:0] match,
                               input logic [31:0] mask);
    return (word & mask) == match;
  endfunction

  logic [31:0] word;
  logic        is_two_op;
  logic        is_three_op;
  logic        is_cvt_s_w;
  logic        is_one_op;
  logic        is_to_int;
  logic        is_vf;
  logic        is_dropped;

  assign word = issue_instr_i.r;

  // Grouped by operand count
  assign is_two_op = hit(word, FaddSMatch, FaddSMask) || hit(word, FsubSMatch, FsubSMask) ||
                     hit(word, FmulSMatch, FmulSMask) || hit(word, FsgnjSMatch, FsgnjSMask) ||
                     hit(word, FminSMatch, FminSMask) || hit(word, FmaxSMatch, FmaxSMask) ||
                     hit(word, FeqSMatch, FeqSMask) || hit(word, FltSMatch, FltSMask) ||
                     hit(word, FleSMatch, FleSMask);
  assign is_three_op = hit(word, FmaddSMatch, FmaddSMask) ||
                       hit(word, FnmaddSMatch, FnmaddSMask);
  assign is_cvt_s_w  = hit(word, FcvtSWMatch, FcvtSWMask);
  assign is_one_op   = is_cvt_s_w || hit(word, FcvtWSMatch, FcvtWSMask) ||
                       hit(word, FclassSMatch, FclassSMask);

  // Results that land in the integer file
  assign is_to_int = hit(word, FeqSMatch, FeqSMask) || hit(word, FltSMatch, FltSMask) ||
                     hit(word, FleSMatch, FleSMask) || hit(word, FclassSMatch, FclassSMask) ||
                     hit(word, FcvtWSMatch, FcvtWSMask);

  assign is_vf = hit(word, VfaddVfMatch, VfaddVfMask) || hit(word, VfmulVfMatch, VfmulVfMask) ||
                 hit(word, VfmaccVfMatch, VfmaccVfMask);

  // No divider and no FP load/store unit
  assign is_dropped = hit(word, FdivSMatch, FdivSMask) || hit(word, FsqrtSMatch, FsqrtSMask) ||
                      hit(word, FlwMatch, FlwMask) || hit(word, FswMatch, FswMask);

  always_comb begin
    use_fs1_o  = 1'b0;
    use_fs2_o  = 1'b0;
    use_fs3_o  = 1'b0;
    use_fd_o   = 1'b0;
    fp_class_o = Forward;
    illegal_o  = 1'b0;
    if (issue_valid_i) begin
      if (is_dropped) begin
        illegal_o = 1'b1;
      end else if (hit(word, FmvXWMatch, FmvXWMask)) begin
        fp_class_o = MoveToInt;
        use_fs1_o  = 1'b1;
      end else if (hit(word, FmvWXMatch, FmvWXMask)) begin
        fp_class_o = MoveToFp;
        use_fd_o   = 1'b1;
      end else if (is_vf) begin
        fp_class_o = Arith;
        use_fs1_o  = 1'b1;
      end else if (is_two_op || is_three_op || is_one_op) begin
        fp_class_o = Arith;
        use_fs1_o  = !is_cvt_s_w;
        use_fs2_o  = is_two_op || is_three_op;
        use_fs3_o  = is_three_op;
        use_fd_o   = !is_to_int;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/fpu_seq_pkg.sv */
////////////////////
// FPU sequencer package
// Widths, instruction views, opcode patterns and result tag layout
////////////////////

`default_nettype none

package fpu_seq_pkg;

  localparam int unsigned Flen      = 32;
  localparam int unsigned NrFpr     = 32;
  localparam int unsigned FprTagBit = 5;

  typedef logic [Flen-1:0]          fp_data_t;
  typedef logic [$clog2(NrFpr)-1:0] fpr_addr_t;
  // Top bit set means the result goes back into the FPR
  typedef logic [FprTagBit:0]       issue_id_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_r_t;

  // Fused multiply-add layout
  typedef struct packed {
    logic [4:0] rs3;
    logic [1:0] fmt;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] rm;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_r4_t;

  typedef union packed {
    instr_r_t  r;
    instr_r4_t r4;
  } instr_u;

  typedef enum logic [1:0] {
    Forward,
    Arith,
    MoveToInt,
    MoveToFp
  } fp_class_e;

  ////////////////////
  // Instruction patterns
  ////////////////////

  localparam logic [31:0] FaddSMatch    = 32'h0000_0053;
  localparam logic [31:0] FaddSMask     = 32'hFE00_007F;
  localparam logic [31:0] FsubSMatch    = 32'h0800_0053;
  localparam logic [31:0] FsubSMask     = 32'hFE00_007F;
  localparam logic [31:0] FmulSMatch    = 32'h1000_0053;
  localparam logic [31:0] FmulSMask     = 32'hFE00_007F;
  localparam logic [31:0] FdivSMatch    = 32'h1800_0053;
  localparam logic [31:0] FdivSMask     = 32'hFE00_007F;
  localparam logic [31:0] FsqrtSMatch   = 32'h5800_0053;
  localparam logic [31:0] FsqrtSMask    = 32'hFFF0_007F;
  localparam logic [31:0] FsgnjSMatch   = 32'h2000_0053;
  localparam logic [31:0] FsgnjSMask    = 32'hFE00_707F;
  localparam logic [31:0] FminSMatch    = 32'h2800_0053;
  localparam logic [31:0] FminSMask     = 32'hFE00_707F;
  localparam logic [31:0] FmaxSMatch    = 32'h2800_1053;
  localparam logic [31:0] FmaxSMask     = 32'hFE00_707F;
  localparam logic [31:0] FeqSMatch     = 32'hA000_2053;
  localparam logic [31:0] FeqSMask      = 32'hFE00_707F;
  localparam logic [31:0] FltSMatch     = 32'hA000_1053;
  localparam logic [31:0] FltSMask      = 32'hFE00_707F;
  localparam logic [31:0] FleSMatch     = 32'hA000_0053;
  localparam logic [31:0] FleSMask      = 32'hFE00_707F;
  localparam logic [31:0] FclassSMatch  = 32'hE000_1053;
  localparam logic [31:0] FclassSMask   = 32'hFFF0_707F;
  localparam logic [31:0] FcvtSWMatch   = 32'hD000_0053;
  localparam logic [31:0] FcvtSWMask    = 32'hFFF0_007F;
  localparam logic [31:0] FcvtWSMatch   = 32'hC000_0053;
  localparam logic [31:0] FcvtWSMask    = 32'hFFF0_007F;
  localparam logic [31:0] FmaddSMatch   = 32'h0000_0043;
  localparam logic [31:0] FmaddSMask    = 32'h0600_007F;
  localparam logic [31:0] FnmaddSMatch  = 32'h0000_004F;
  localparam logic [31:0] FnmaddSMask   = 32'h0600_007F;
  localparam logic [31:0] FmvXWMatch    = 32'hE000_0053;
  localparam logic [31:0] FmvXWMask     = 32'hFFF0_707F;
  localparam logic [31:0] FmvWXMatch    = 32'hF000_0053;
  localparam logic [31:0] FmvWXMask     = 32'hFFF0_707F;
  localparam logic [31:0] FlwMatch      = 32'h0000_2007;
  localparam logic [31:0] FlwMask       = 32'h0000_707F;
  localparam logic [31:0] FswMatch      = 32'h0000_2027;
  localparam logic [31:0] FswMask       = 32'h0000_707F;
  // Vector ops with a scalar FP operand
  localparam logic [31:0] VfaddVfMatch  = 32'h0000_5057;
  localparam logic [31:0] VfaddVfMask   = 32'hFC00_707F;
  localparam logic [31:0] VfmulVfMatch  = 32'h9000_5057;
  localparam logic [31:0] VfmulVfMask   = 32'hFC00_707F;
  localparam logic [31:0] VfmaccVfMatch = 32'hB000_5057;
  localparam logic [31:0] VfmaccVfMask  = 32'hFC00_707F;

endpackage

`default_nettype wire
